// ==== design/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

	localparam int WORD_W = 10;
	localparam int CFG_W  = 7;

	typedef logic [WORD_W-1:0] lcd_word_t;  // {rs, rw, data}
	typedef logic [CFG_W-1:0]  lcd_cfg_t;   // {lines, font, disp, cursor, blink, inc, shift}
	typedef logic [3:0]        lcd_col_t;   // column within one line

	// bus word fields
	localparam int RS_BIT   = 9;
	localparam int RW_BIT   = 8;
	localparam int DATA_MSB = 7;

	// set-ddram-address command fields
	localparam int ADDR_CMD_BIT  = 7;
	localparam int ADDR_LINE_BIT = 6;

	// configuration bits, highest first
	localparam int CFG_LINES   = 6;
	localparam int CFG_FONT    = 5;
	localparam int CFG_DISPLAY = 4;
	localparam int CFG_CURSOR  = 3;
	localparam int CFG_BLINK   = 2;
	localparam int CFG_INC     = 1;
	localparam int CFG_SHIFT   = 0;

	localparam int         LCD_COLS   = 16;
	localparam logic [7:0] LINE0_BASE = 8'h80;
	localparam logic [7:0] LINE1_BASE = 8'hC0;
	localparam logic [7:0] CMD_CLEAR  = 8'h01;
	localparam logic [7:0] CMD_HOME   = 8'h02;

	// timing in microseconds, scaled by CLK_PER_US where used
	localparam int T_POWER_UP   = 500;
	localparam int T_EN_SETUP   = 1;
	localparam int T_EN_HIGH    = 13;
	localparam int T_SLOT       = 50;
	localparam int T_GAP_FUNC   = 50;
	localparam int T_GAP_DISP   = 50;
	localparam int T_GAP_CLEAR  = 200;
	localparam int T_GAP_ENTRY  = 100;
	localparam int T_INIT_PULSE = 10;

endpackage

`default_nettype wire

// ==== design/lcd_request_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_request_port (
	input  logic               clk,
	input  logic               rst,
	input  logic               req,
	input  lcd_pkg::lcd_word_t word,
	output logic               ack,
	output logic               req_valid,
	output lcd_pkg::lcd_word_t req_word,
	input  logic               req_ready
);
	import lcd_pkg::*;

	typedef enum logic [1:0] {
		HS_IDLE,
		HS_ACKED,
		HS_WAIT_RELEASE
	} hs_state_t;

	hs_state_t state;
	logic      full;   // holding register occupied
	logic      take;

	// latch only when not already acked and the register is free
	assign take      = req && !full && (state != HS_ACKED);
	assign req_valid = full;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= HS_IDLE;
			ack   <= 1'b0;
			full  <= 1'b0;
		end else begin
			if (req_valid && req_ready)
				full <= 1'b0;          // word moved to tracker
			if (take)
				full <= 1'b1;
			case (state)
				HS_IDLE: begin
					if (take) begin
						ack   <= 1'b1;
						state <= HS_ACKED;
					end else if (req) begin
						state <= HS_WAIT_RELEASE;   // register still full
					end
				end
				HS_WAIT_RELEASE: begin
					if (take) begin
						ack   <= 1'b1;
						state <= HS_ACKED;
					end else if (!req) begin
						state <= HS_IDLE;   // host withdrew
					end
				end
				HS_ACKED: begin
					if (!req) begin
						ack   <= 1'b0;      // phase four
						state <= HS_IDLE;
					end
				end
				default: state <= HS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			req_word <= word;
	end

endmodule

`default_nettype wire

// ==== design/lcd_cursor_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_cursor_tracker (
	input  logic               clk,
	input  logic               rst,
	input  logic               req_valid,
	input  lcd_pkg::lcd_word_t req_word,
	output logic               req_ready,
	output logic               trk_valid,
	output lcd_pkg::lcd_word_t trk_word,
	input  logic               trk_ready
);
	import lcd_pkg::*;

	typedef enum logic [1:0] {
		TRK_EMPTY,
		TRK_HOLD,
		TRK_INSERT
	} trk_state_t;

	trk_state_t state;
	lcd_word_t  held;        // character parked behind a line change
	logic       line;
	lcd_col_t   col;
	logic       line_full;   // column has reached LCD_COLS
	logic       is_data;
	logic       is_cmd;
	logic       is_home;
	logic       is_set_addr;
	logic       need_wrap;
	logic       accept;

	assign is_data     = req_word[RS_BIT] && !req_word[RW_BIT];
	assign is_cmd      = !req_word[RS_BIT] && !req_word[RW_BIT];
	assign is_home     = is_cmd && (req_word[DATA_MSB:0] == CMD_CLEAR ||
		req_word[DATA_MSB:0] == CMD_HOME);
	assign is_set_addr = is_cmd && req_word[ADDR_CMD_BIT];
	assign need_wrap   = is_data && line_full;

	assign req_ready = (state == TRK_EMPTY);
	assign trk_valid = (state != TRK_EMPTY);
	assign accept    = req_valid && req_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= TRK_EMPTY;
			line      <= 1'b0;
			col       <= '0;
			line_full <= 1'b0;
		end else begin
			case (state)
				TRK_EMPTY: begin
					if (accept) begin
						state <= need_wrap ? TRK_INSERT : TRK_HOLD;
						if (is_home) begin
							line      <= 1'b0;
							col       <= '0;
							line_full <= 1'b0;
						end else if (is_set_addr) begin
							line      <= req_word[ADDR_LINE_BIT];
							col       <= req_word[3:0];
							line_full <= 1'b0;
						end else if (is_data && !line_full) begin
							if (col == lcd_col_t'(LCD_COLS - 1))
								line_full <= 1'b1;
							col <= col + 1'b1;   // wraps to 0 with line_full set
						end
					end
				end
				TRK_INSERT: begin
					if (trk_ready) begin
						state     <= TRK_HOLD;
						line      <= !line;
						col       <= lcd_col_t'(1);   // character lands in column 0
						line_full <= 1'b0;
					end
				end
				TRK_HOLD: begin
					if (trk_ready)
						state <= TRK_EMPTY;
				end
				default: state <= TRK_EMPTY;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == TRK_EMPTY && accept) begin
			held <= req_word;
			if (need_wrap)
				trk_word <= {1'b0, 1'b0, line ? LINE0_BASE : LINE1_BASE};
			else
				trk_word <= req_word;
		end else if (state == TRK_INSERT && trk_ready) begin
			trk_word <= held;
		end
	end

endmodule

`default_nettype wire

// ==== design/lcd_bus_timing.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_bus_timing #(
	parameter int CLK_PER_US = 2
) (
	input  logic               clk,
	input  logic               rst,
	input  lcd_pkg::lcd_cfg_t  cfg,
	input  logic               trk_valid,
	input  lcd_pkg::lcd_word_t trk_word,
	output logic               trk_ready,
	output logic               e,
	output logic               rs,
	output logic               rw,
	output logic [7:0]         lcd_data,
	output logic               busy
);
	import lcd_pkg::*;

	// power-up wait is the longest interval counted
	localparam int CNT_MAX = T_POWER_UP * CLK_PER_US;
	localparam int CNT_W   = $clog2(CNT_MAX + 1);

	typedef logic [CNT_W-1:0] cnt_t;

	typedef enum logic [1:0] {
		BT_POWER_UP,
		BT_INIT_SEQ,
		BT_IDLE,
		BT_WRITE
	} bt_state_t;

	localparam cnt_t PU_LAST    = cnt_t'(T_POWER_UP * CLK_PER_US - 1);
	localparam cnt_t PULSE_LAST = cnt_t'(T_INIT_PULSE * CLK_PER_US - 1);
	localparam cnt_t SETUP_LAST = cnt_t'(T_EN_SETUP * CLK_PER_US - 1);
	localparam cnt_t HIGH_LAST  = cnt_t'((T_EN_SETUP + T_EN_HIGH) * CLK_PER_US - 1);
	localparam cnt_t SLOT_LAST  = cnt_t'(T_SLOT * CLK_PER_US - 1);

	bt_state_t  state;
	cnt_t       cnt;
	logic [1:0] step;     // init command index
	logic       accept;

	// last count of an init step, pulse plus its gap
	function automatic cnt_t step_last(input logic [1:0] idx);
		int gap_us;
		case (idx)
			2'd0:    gap_us = T_GAP_FUNC;
			2'd1:    gap_us = T_GAP_DISP;
			2'd2:    gap_us = T_GAP_CLEAR;
			default: gap_us = T_GAP_ENTRY;
		endcase
		return cnt_t'((T_INIT_PULSE + gap_us) * CLK_PER_US - 1);
	endfunction

	function automatic logic [7:0] init_cmd(input logic [1:0] idx, input lcd_cfg_t c);
		logic [7:0] cmd;
		case (idx)
			2'd0:    cmd = {4'b0011, c[CFG_LINES], c[CFG_FONT], 2'b00};   // function set
			2'd1:    cmd = {5'b00001, c[CFG_DISPLAY], c[CFG_CURSOR], c[CFG_BLINK]};
			2'd2:    cmd = CMD_CLEAR;
			default: cmd = {6'b000001, c[CFG_INC], c[CFG_SHIFT]};          // entry mode
		endcase
		return cmd;
	endfunction

	assign trk_ready = (state == BT_IDLE);
	assign accept    = trk_valid && trk_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= BT_POWER_UP;
			cnt      <= '0;
			step     <= '0;
			e        <= 1'b0;
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= '0;
			busy     <= 1'b1;
		end else begin
			case (state)
				BT_POWER_UP: begin
					if (cnt == PU_LAST) begin
						cnt      <= '0;
						step     <= '0;
						e        <= 1'b1;
						lcd_data <= init_cmd(2'd0, cfg);
						state    <= BT_INIT_SEQ;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				BT_INIT_SEQ: begin
					if (cnt == PULSE_LAST)
						e <= 1'b0;
					if (cnt == step_last(step)) begin
						cnt <= '0;
						if (step == 2'd3) begin
							busy  <= 1'b0;       // init done
							state <= BT_IDLE;
						end else begin
							step     <= step + 1'b1;
							e        <= 1'b1;
							lcd_data <= init_cmd(step + 2'd1, cfg);
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				BT_IDLE: begin
					if (accept) begin
						rs       <= trk_word[RS_BIT];
						rw       <= trk_word[RW_BIT];
						lcd_data <= trk_word[DATA_MSB:0];
						busy     <= 1'b1;
						cnt      <= '0;
						state    <= BT_WRITE;
					end
				end
				BT_WRITE: begin
					if (cnt == SETUP_LAST)
						e <= 1'b1;           // after address setup
					if (cnt == HIGH_LAST)
						e <= 1'b0;           // panel latches here
					if (cnt == SLOT_LAST) begin
						cnt   <= '0;
						busy  <= 1'b0;
						state <= BT_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= BT_POWER_UP;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/lcd_text_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_text_top #(
	parameter int CLK_PER_US = 2
) (
	input  logic               clk,
	input  logic               rst,
	input  lcd_pkg::lcd_cfg_t  cfg,
	input  logic               req,
	input  lcd_pkg::lcd_word_t word,
	output logic               ack,
	output logic               e,
	output logic               rs,
	output logic               rw,
	output logic [7:0]         lcd_data,
	output logic               busy
);
	import lcd_pkg::*;

	logic      req_valid;
	lcd_word_t req_word;
	logic      req_ready;
	logic      trk_valid;
	lcd_word_t trk_word;
	logic      trk_ready;

	lcd_request_port u_req (   // host handshake
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.word      (word),
		.ack       (ack),
		.req_valid (req_valid),
		.req_word  (req_word),
		.req_ready (req_ready)
	);

	lcd_cursor_tracker u_trk (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_word  (req_word),
		.req_ready (req_ready),
		.trk_valid (trk_valid),
		.trk_word  (trk_word),
		.trk_ready (trk_ready)
	);

	lcd_bus_timing #(
		.CLK_PER_US (CLK_PER_US)
	) u_bus (
		.clk       (clk),
		.rst       (rst),
		.cfg       (cfg),
		.trk_valid (trk_valid),
		.trk_word  (trk_word),
		.trk_ready (trk_ready),
		.e         (e),
		.rs        (rs),
		.rw        (rw),
		.lcd_data  (lcd_data),
		.busy      (busy)
	);

endmodule

`default_nettype wire

// ==== tests/lcd_panel_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_panel_model (
	input  logic               clk,
	input  logic               rst,
	input  logic               e,
	input  logic               rs,
	input  logic               rw,
	input  logic [7:0]         lcd_data,
	output logic               cap_valid,
	output lcd_pkg::lcd_word_t cap_word,
	output logic [15:0]        cap_width,
	output logic [15:0]        cap_spacing
);
	logic        e_q;
	logic [15:0] high_cnt;   // samples with e high
	logic [15:0] rise_cnt;   // cycles since e last rose

	always_ff @(posedge clk) begin
		if (rst) begin
			e_q       <= 1'b0;
			high_cnt  <= '0;
			rise_cnt  <= '0;
			cap_valid <= 1'b0;
		end else begin
			e_q       <= e;
			cap_valid <= 1'b0;
			if (e)
				high_cnt <= high_cnt + 1'b1;
			if (e && !e_q) begin
				cap_spacing <= rise_cnt;   // rise to rise
				rise_cnt    <= 16'd1;
			end else if (rise_cnt != '1) begin
				rise_cnt <= rise_cnt + 1'b1;
			end
			if (!e && e_q) begin   // panel latches on the falling edge
				cap_valid <= 1'b1;
				cap_word  <= {rs, rw, lcd_data};
				cap_width <= high_cnt;
				high_cnt  <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tests/lcd_text_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_text_chk (
	input logic       clk,
	input logic       rst,
	input logic       e,
	input logic       rs,
	input logic       rw,
	input logic [7:0] lcd_data,
	input logic       busy,
	input logic       trk_ready
);

	// the panel samples rs, rw and data across the whole pulse
	pins_stable: assert property (@(posedge clk) disable iff (rst)
		(e && $past(e)) |-> $stable({rs, rw, lcd_data}))
		else $error("rs, rw or lcd_data changed while e was high");

	busy_with_e: assert property (@(posedge clk) disable iff (rst) e |-> busy)
		else $error("e high outside a busy slot");

	ready_when_idle: assert property (@(posedge clk) disable iff (rst) trk_ready |-> !busy)
		else $error("trk_ready high during a busy slot");

endmodule

bind lcd_bus_timing lcd_text_chk chk (
	.clk       (clk),
	.rst       (rst),
	.e         (e),
	.rs        (rs),
	.rw        (rw),
	.lcd_data  (lcd_data),
	.busy      (busy),
	.trk_ready (trk_ready)
);

`default_nettype wire

// ==== tests/lcd_text_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_text_tb;
	import lcd_pkg::*;

	localparam int CLK_PER_US  = 2;
	localparam int N_TESTS     = 6;
	localparam int MAX_WORDS   = 128;
	localparam int TIMEOUT     = 20000;   // init plus about 60 slots with margin
	localparam int INIT_CYCLES = (500 + 60 + 60 + 210 + 110) * CLK_PER_US;
	localparam int INIT_HIGH   = 10 * CLK_PER_US;
	localparam int WRITE_HIGH  = 13 * CLK_PER_US;
	localparam int SLOT        = 50 * CLK_PER_US;

	logic        clk, rst, req, ack, e, rs, rw, busy;
	lcd_cfg_t    cfg;
	lcd_word_t   word;
	logic [7:0]  lcd_data;
	logic        cap_valid;
	lcd_word_t   cap_word;
	logic [15:0] cap_width, cap_spacing;

	lcd_word_t   stim [MAX_WORDS], exp_word [MAX_WORDS], got_word [MAX_WORDS];
	int          stim_test [MAX_WORDS], exp_test [MAX_WORDS];
	logic [15:0] got_width [MAX_WORDS], got_spacing [MAX_WORDS];
	int          n_stim, n_exp, errors, passed;
	int          n_got = 0;
	int          cycles = 0;
	integer      seed;

	lcd_text_top #(.CLK_PER_US(CLK_PER_US)) UUT (
		.clk(clk), .rst(rst), .cfg(cfg), .req(req), .word(word), .ack(ack),
		.e(e), .rs(rs), .rw(rw), .lcd_data(lcd_data), .busy(busy)
	);

	lcd_panel_model panel (
		.clk(clk), .rst(rst), .e(e), .rs(rs), .rw(rw), .lcd_data(lcd_data),
		.cap_valid(cap_valid), .cap_word(cap_word), .cap_width(cap_width),
		.cap_spacing(cap_spacing)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout after %0d cycles, the DUT stopped delivering words", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	always @(posedge clk) begin
		if (cap_valid && n_got < MAX_WORDS) begin
			got_word[n_got]    <= cap_word;
			got_width[n_got]   <= cap_width;
			got_spacing[n_got] <= cap_spacing;
			n_got              <= n_got + 1;
		end
	end

	function automatic lcd_word_t char_word(input int i);
		return {1'b1, 1'b0, 8'h41 + 8'(i)};   // 'A' onwards
	endfunction

	function automatic lcd_word_t cmd_word(input logic [7:0] c);
		return {2'b00, c};
	endfunction

	task automatic add_stim(input int t, input lcd_word_t w);
		stim[n_stim]      = w;
		stim_test[n_stim] = t;
		n_stim++;
	endtask

	task automatic add_exp(input int t, input lcd_word_t w);
		exp_word[n_exp] = w;
		exp_test[n_exp] = t;
		n_exp++;
	endtask

	// host words and expected bus words per test
	task automatic build_tables();
		int i;
		n_stim = 0;
		n_exp  = 0;
		add_exp(0, cmd_word(8'h38));
		add_exp(0, cmd_word(8'h0C));
		add_exp(0, cmd_word(8'h01));
		add_exp(0, cmd_word(8'h06));
		add_stim(1, char_word(0));
		add_exp(1, char_word(0));
		add_stim(2, cmd_word(CMD_CLEAR));
		add_exp(2, cmd_word(CMD_CLEAR));
		for (i = 0; i < 17; i++) begin
			add_stim(2, char_word(i));
			if (i == 16)
				add_exp(2, cmd_word(8'hC0));   // line 0 full
			add_exp(2, char_word(i));
		end
		for (i = 0; i < 3; i++) begin
			add_stim(3, char_word(i));
			add_exp(3, char_word(i));
		end
		add_stim(3, cmd_word(CMD_CLEAR));
		add_exp(3, cmd_word(CMD_CLEAR));
		for (i = 0; i < 17; i++) begin
			add_stim(3, char_word(i));
			if (i == 16)
				add_exp(3, cmd_word(8'hC0));
			add_exp(3, char_word(i));
		end
		add_stim(4, cmd_word(8'hC5));   // line 1, column 5
		add_exp(4, cmd_word(8'hC5));
		for (i = 0; i < 12; i++) begin
			add_stim(4, char_word(i));
			if (i == 11)
				add_exp(4, cmd_word(8'h80));   // back to line 0
			add_exp(4, char_word(i));
		end
		for (i = 0; i < 8; i++) begin
			add_stim(5, char_word(i));
			add_exp(5, char_word(i));
		end
	endtask

	task automatic send_word(input lcd_word_t w, output int waited);
		waited = 0;
		@(posedge clk);
		word <= w;
		req  <= 1'b1;
		@(posedge clk);
		while (!ack) begin
			waited++;
			@(posedge clk);
		end
		req <= 1'b0;
		@(posedge clk);
		while (ack)
			@(posedge clk);
	endtask

	task automatic check_test(input int t);
		int i;
		int want_width;
		want_width = (t == 0) ? INIT_HIGH : WRITE_HIGH;
		for (i = 0; i < n_exp; i++) begin
			if (exp_test[i] != t)
				continue;
			if (i >= n_got) begin
				$display("test %0d: bus word %0d never reached the panel", t + 1, i);
				errors++;
				continue;
			end
			if (got_word[i] !== exp_word[i]) begin
				$display("CHECK FAILED at %0t: {rs,rw,lcd_data} word %0d expected %h got %h",
					$time, i, exp_word[i], got_word[i]);
				errors++;
			end
			if (int'(got_width[i]) != want_width) begin
				$display("CHECK FAILED at %0t: e high width word %0d expected %0d got %0d",
					$time, i, want_width, got_width[i]);
				errors++;
			end
			if (t > 0 && int'(got_spacing[i]) < SLOT) begin
				$display("CHECK FAILED at %0t: e rise spacing word %0d expected >= %0d got %0d",
					$time, i, SLOT, got_spacing[i]);
				errors++;
			end
		end
	endtask

	initial begin
		int t;
		int i;
		int n;
		int waited;
		int stall_max;
		int gap;
		int snap;
		int target;
		rst    = 1'b1;
		req    = 1'b0;
		word   = '0;
		cfg    = 7'b1010010;   // two lines, 5x8 font, display on, increment
		errors = 0;
		passed = 0;
		snap   = 0;
		seed   = 32'h6d6d;
		build_tables();
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (busy && n < INIT_CYCLES + 100);
		if (busy) begin
			$display("busy never fell after the initialization sequence");
			errors++;
		end else if (n < INIT_CYCLES || n > INIT_CYCLES + 2) begin
			$display("CHECK FAILED at %0t: busy fall cycle expected %0d got %0d",
				$time, INIT_CYCLES + 1, n);
			errors++;
		end
		for (t = 0; t < N_TESTS; t++) begin
			stall_max = 0;
			target    = 0;
			for (i = 0; i < n_stim; i++) begin
				if (stim_test[i] != t)
					continue;
				send_word(stim[i], waited);
				if (waited > stall_max)
					stall_max = waited;
				if (t == N_TESTS - 1)
					gap = 0;   // back to back
				else
					gap = $unsigned($random(seed)) % 8;
				repeat (gap) @(posedge clk);
			end
			for (i = 0; i < n_exp; i++)
				if (exp_test[i] == t)
					target = i + 1;
			n = 0;
			while (n_got < target && n < 5 * SLOT) begin
				@(posedge clk);
				n++;
			end
			check_test(t);
			if (t == N_TESTS - 1 && stall_max < SLOT / 2) begin
				$display("CHECK FAILED at %0t: ack wait cycles expected >= %0d got %0d",
					$time, SLOT / 2, stall_max);
				errors++;
			end
			if (errors == snap) begin
				passed++;
				$display("test %0d: ok", t + 1);
			end else begin
				$display("test %0d: %0d errors", t + 1, errors - snap);
			end
			snap = errors;
		end
		repeat (2 * SLOT) @(posedge clk);
		if (n_got != n_exp) begin
			$display("panel saw %0d bus words where %0d were expected", n_got, n_exp);
			errors++;
		end
		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			N_TESTS, passed, N_TESTS - passed, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
design/lcd_pkg.sv
design/lcd_request_port.sv
design/lcd_cursor_tracker.sv
design/lcd_bus_timing.sv
design/lcd_text_top.sv
tests/lcd_panel_model.sv
tests/lcd_text_chk.sv
tests/lcd_text_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = lcd_text_tb
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "sim: failure reported in $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "sim: run ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
